// File: src/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    //////////////////////////////
    // Bus and pixel types
    //////////////////////////////
    typedef logic [15:0] vram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  color_t;

    //////////////////////////////
    // VRAM layout
    //////////////////////////////
    localparam vram_addr_t map_base_lo        = 16'h9800;
    localparam vram_addr_t map_base_hi        = 16'h9C00;
    localparam vram_addr_t tile_base_unsigned = 16'h8000;
    // Centre of the signed block, index -128 lands on 8800h
    localparam vram_addr_t tile_base_signed   = 16'h9000;

    // LCDC bit positions
    localparam int lcdc_bg_en    = 0;
    localparam int lcdc_map_sel  = 3;
    localparam int lcdc_data_sel = 4;

    //////////////////////////////
    // Screen geometry
    //////////////////////////////
    localparam int screen_w       = 160;
    localparam int tile_px        = 8;
    localparam int map_w          = 32;
    localparam int tiles_per_line = screen_w / tile_px + 1;

endpackage

`default_nettype wire

// File: src/tile_addr_calc.sv
`timescale 1ns/1ps
`default_nettype none

module tile_addr_calc (
    input  wire ppu_pkg::byte_t      lcdc,
    input  wire ppu_pkg::byte_t      scx,
    input  wire ppu_pkg::byte_t      scy,
    input  wire ppu_pkg::byte_t      ly,
    input  wire logic [4:0]          tile_col,
    input  wire ppu_pkg::byte_t      tile_index,
    input  wire logic                addr_sel,
    output ppu_pkg::vram_addr_t      map_addr,
    output ppu_pkg::vram_addr_t      data_addr
);

    logic [4:0]          map_col;
    ppu_pkg::byte_t      map_row;
    ppu_pkg::vram_addr_t map_base;
    ppu_pkg::vram_addr_t tile_addr;
    ppu_pkg::vram_addr_t row_off;

    //////////////////////////////
    // Tile map address
    //////////////////////////////
    always_comb begin
        // Coarse scroll wraps around the 32 tile map row
        map_col  = scx[7:3] + tile_col;
        map_row  = scy + ly;
        map_base = lcdc[ppu_pkg::lcdc_map_sel] ? ppu_pkg::map_base_hi : ppu_pkg::map_base_lo;
        map_addr = map_base
                 + ppu_pkg::vram_addr_t'(map_row[7:3]) * 16'(ppu_pkg::map_w)
                 + ppu_pkg::vram_addr_t'(map_col);
    end

    //////////////////////////////
    // Tile data address
    //////////////////////////////
    always_comb begin
        if (lcdc[ppu_pkg::lcdc_data_sel]) begin
            tile_addr = ppu_pkg::tile_base_unsigned + {4'b0000, tile_index, 4'b0000};
        end else begin
            // Sign extended index, 16 bytes per tile
            tile_addr = ppu_pkg::tile_base_signed + {{4{tile_index[7]}}, tile_index, 4'b0000};
        end
        // Two bytes per tile row, high plane is the odd byte
        row_off   = {12'h000, map_row[2:0], addr_sel};
        data_addr = tile_addr + row_off;
    end

endmodule

`default_nettype wire

// File: src/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter int read_cycles = 2
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire ppu_pkg::byte_t      vram_dout,
    input  wire ppu_pkg::vram_addr_t map_addr,
    input  wire ppu_pkg::vram_addr_t data_addr,
    input  wire logic                row_ready,
    output ppu_pkg::vram_addr_t      vram_a,
    output logic [4:0]               tile_col,
    output ppu_pkg::byte_t           tile_index,
    output logic                     addr_sel,
    output logic                     row_valid,
    output ppu_pkg::byte_t           plane_lo,
    output ppu_pkg::byte_t           plane_hi
);

    localparam int cnt_w = $clog2(read_cycles);

    typedef enum logic [2:0] {
        s_idle,
        s_map,
        s_lo,
        s_hi,
        s_push
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] cnt;
    logic             last;

    // Byte is valid on the last cycle the address is held
    assign last = (cnt == cnt_w'(read_cycles - 1));

    //////////////////////////////
    // VRAM address port
    //////////////////////////////
    always_comb begin
        addr_sel = (state == s_hi);
        if (state == s_lo || state == s_hi) begin
            vram_a = data_addr;
        end else begin
            vram_a = map_addr;
        end
    end

    // Row goes out only when the serializer can take it
    assign row_valid = (state == s_push) && row_ready;

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= s_idle;
            cnt      <= '0;
            tile_col <= '0;
        end else if (start) begin
            state    <= s_map;
            cnt      <= '0;
            tile_col <= '0;
        end else begin
            case (state)
                s_map: begin
                    cnt <= last ? '0 : cnt + 1'b1;
                    if (last) begin
                        state <= s_lo;
                    end
                end
                s_lo: begin
                    cnt <= last ? '0 : cnt + 1'b1;
                    if (last) begin
                        state <= s_hi;
                    end
                end
                s_hi: begin
                    cnt <= last ? '0 : cnt + 1'b1;
                    if (last) begin
                        state <= s_push;
                    end
                end
                s_push: begin
                    if (row_ready) begin
                        if (tile_col == 5'(ppu_pkg::tiles_per_line - 1)) begin
                            state <= s_idle;
                        end else begin
                            tile_col <= tile_col + 5'd1;
                            state    <= s_map;
                        end
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Fetched bytes
    always_ff @(posedge clk) begin
        if (last) begin
            if (state == s_map) begin
                tile_index <= vram_dout;
            end
            if (state == s_lo) begin
                plane_lo <= vram_dout;
            end
            if (state == s_hi) begin
                plane_hi <= vram_dout;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_serializer (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           start,
    input  wire ppu_pkg::byte_t scx,
    input  wire ppu_pkg::byte_t lcdc,
    input  wire logic           row_valid,
    input  wire ppu_pkg::byte_t plane_lo,
    input  wire ppu_pkg::byte_t plane_hi,
    input  wire logic           fifo_empty,
    output logic                row_ready,
    output logic                fifo_write,
    output ppu_pkg::color_t     pixel_out,
    output logic                done
);

    ppu_pkg::byte_t  sh_lo;
    ppu_pkg::byte_t  sh_hi;
    logic [3:0]      rem;
    logic [2:0]      skip_cnt;
    logic [7:0]      px_cnt;
    logic            buf_empty;
    logic            emit;
    ppu_pkg::color_t color;

    assign buf_empty = (rem == 4'd0);
    assign row_ready = buf_empty && fifo_empty;

    // MSB is the leftmost pixel
    assign color = lcdc[ppu_pkg::lcdc_bg_en] ? {sh_hi[7], sh_lo[7]} : 2'b00;
    assign emit  = !buf_empty && (skip_cnt == 3'd0) && (px_cnt < 8'(ppu_pkg::screen_w));

    //////////////////////////////
    // Line control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rem        <= '0;
            skip_cnt   <= '0;
            px_cnt     <= '0;
            fifo_write <= 1'b0;
            done       <= 1'b0;
        end else if (start) begin
            rem        <= '0;
            skip_cnt   <= scx[2:0];
            px_cnt     <= '0;
            fifo_write <= 1'b0;
            done       <= 1'b0;
        end else begin
            fifo_write <= emit;
            done       <= 1'b0;
            if (row_valid) begin
                rem <= 4'(ppu_pkg::tile_px);
            end else if (!buf_empty) begin
                rem <= rem - 4'd1;
                // Fine scroll drops pixels of the first tile only
                if (skip_cnt != 3'd0) begin
                    skip_cnt <= skip_cnt - 3'd1;
                end
            end
            if (emit) begin
                px_cnt <= px_cnt + 8'd1;
            end else if (px_cnt == 8'(ppu_pkg::screen_w)) begin
                // Step past screen_w so done fires once
                px_cnt <= px_cnt + 8'd1;
                done   <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Row buffer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (row_valid) begin
            sh_lo <= plane_lo;
            sh_hi <= plane_hi;
        end else if (!buf_empty) begin
            sh_lo <= {sh_lo[6:0], 1'b0};
            sh_hi <= {sh_hi[6:0], 1'b0};
        end
        if (emit) begin
            pixel_out <= color;
        end
    end

endmodule

`default_nettype wire

// File: src/bg_fetcher_top.sv
`timescale 1ns/1ps
`default_nettype none

module bg_fetcher_top #(
    parameter int read_cycles = 2
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire ppu_pkg::byte_t      lcdc,
    input  wire ppu_pkg::byte_t      scx,
    input  wire ppu_pkg::byte_t      scy,
    input  wire ppu_pkg::byte_t      ly,
    input  wire ppu_pkg::byte_t      vram_dout,
    input  wire logic                fifo_empty,
    output ppu_pkg::vram_addr_t      vram_a,
    output logic                     fifo_write,
    output ppu_pkg::color_t          pixel_out,
    output logic                     done
);

    // Address calculator links
    logic [4:0]          tile_col;
    ppu_pkg::byte_t      tile_index;
    logic                addr_sel;
    ppu_pkg::vram_addr_t map_addr;
    ppu_pkg::vram_addr_t data_addr;

    // Row handoff
    logic                row_valid;
    logic                row_ready;
    ppu_pkg::byte_t      plane_lo;
    ppu_pkg::byte_t      plane_hi;

    fetch_sequencer #(
        .read_cycles (read_cycles)
    ) seq0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .vram_dout  (vram_dout),
        .map_addr   (map_addr),
        .data_addr  (data_addr),
        .row_ready  (row_ready),
        .vram_a     (vram_a),
        .tile_col   (tile_col),
        .tile_index (tile_index),
        .addr_sel   (addr_sel),
        .row_valid  (row_valid),
        .plane_lo   (plane_lo),
        .plane_hi   (plane_hi)
    );

    tile_addr_calc addr0 (
        .lcdc       (lcdc),
        .scx        (scx),
        .scy        (scy),
        .ly         (ly),
        .tile_col   (tile_col),
        .tile_index (tile_index),
        .addr_sel   (addr_sel),
        .map_addr   (map_addr),
        .data_addr  (data_addr)
    );

    pixel_serializer ser0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .scx        (scx),
        .lcdc       (lcdc),
        .row_valid  (row_valid),
        .plane_lo   (plane_lo),
        .plane_hi   (plane_hi),
        .fifo_empty (fifo_empty),
        .row_ready  (row_ready),
        .fifo_write (fifo_write),
        .pixel_out  (pixel_out),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 10 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_vram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vram (
    input  wire logic                clk,
    input  wire ppu_pkg::vram_addr_t a,
    output logic [7:0]               dout,
    input  wire ppu_pkg::byte_t      lcdc,
    input  wire ppu_pkg::byte_t      scx,
    input  wire ppu_pkg::byte_t      scy,
    input  wire ppu_pkg::byte_t      ly,
    input  wire integer              x,
    output logic [1:0]               ref_px
);

    // 8000h..9FFFh
    logic [7:0] mem [0:8191];

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    initial begin
        logic [31:0] s;
        s = 32'd20;
        for (int i = 0; i < 8192; i++) begin
            s = next_rand(s);
            mem[i] = s[7:0];
        end
        dout = 8'h00;
    end

    always @(posedge clk) begin
        dout <= mem[a[12:0]];
    end

    // Colour of screen pixel x from the map, tile data and registers
    function automatic logic [1:0] ref_color(input int px);
        int         sx;
        int         row;
        int         map_a;
        int         idx;
        int         tile_a;
        logic [12:0] ia;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [2:0] b;
        sx    = (px + int'(scx)) % 256;
        row   = (int'(scy) + int'(ly)) % 256;
        map_a = (lcdc[3] ? 'h9C00 : 'h9800) + (row / 8) * 32 + (sx / 8) % 32;
        ia    = 13'(map_a - 'h8000);
        idx   = int'(mem[ia]);
        if (lcdc[4]) begin
            tile_a = 'h8000 + idx * 16;
        end else begin
            tile_a = 'h9000 + (idx >= 128 ? idx - 256 : idx) * 16;
        end
        tile_a = tile_a + (row % 8) * 2;
        ia     = 13'(tile_a - 'h8000);
        lo     = mem[ia];
        hi     = mem[ia + 13'd1];
        b      = 3'(7 - sx % 8);
        if (!lcdc[0]) begin
            return 2'b00;
        end
        return {hi[b], lo[b]};
    endfunction

    always_comb begin
        ref_px = ref_color(x);
    end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int read_cycles = 2;
    localparam int n_lines     = 8;
    localparam int limit       = n_lines * ppu_pkg::tiles_per_line * (3 * read_cycles + 40);

    logic                clk;
    logic                rst_n;
    logic                start;
    ppu_pkg::byte_t      lcdc;
    ppu_pkg::byte_t      scx;
    ppu_pkg::byte_t      scy;
    ppu_pkg::byte_t      ly;
    logic [7:0]          vram_dout;
    logic                fifo_empty;
    ppu_pkg::vram_addr_t vram_a;
    logic                fifo_write;
    ppu_pkg::color_t     pixel_out;
    logic                done;
    logic [1:0]          ref_px;

    int          errors = 0;
    int          cyc = 0;
    int          wr_cnt = 0;
    int          lines_run = 0;
    logic        line_done = 1'b0;
    logic [31:0] rng = 32'd20;
    int          stretch = 0;

    tb_clock clk0 (.clk(clk), .rst_n(rst_n));

    tb_vram vram0 (
        .clk(clk), .a(vram_a), .dout(vram_dout),
        .lcdc(lcdc), .scx(scx), .scy(scy), .ly(ly),
        .x(wr_cnt), .ref_px(ref_px)
    );

    bg_fetcher_top #(.read_cycles(read_cycles)) dut0 (
        .clk(clk), .rst_n(rst_n), .start(start),
        .lcdc(lcdc), .scx(scx), .scy(scy), .ly(ly),
        .vram_dout(vram_dout), .fifo_empty(fifo_empty),
        .vram_a(vram_a), .fifo_write(fifo_write),
        .pixel_out(pixel_out), .done(done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    //////////////////////////////
    // Line bookkeeping
    //////////////////////////////
    always_ff @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst_n || start) begin
            wr_cnt    <= 0;
            line_done <= 1'b0;
        end else begin
            if (fifo_write) begin
                wr_cnt <= wr_cnt + 1;
            end
            if (done) begin
                line_done <= 1'b1;
            end
        end
        if (cyc >= limit) begin
            $display("Timeout: no done after %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Random stalls with the FIFO mostly empty
    always @(posedge clk) begin
        #1;
        if (stretch == 0) begin
            rng        = xorshift(rng);
            fifo_empty = rng[0] | rng[1];
            stretch    = int'(rng[4:2]) + 1;
        end
        stretch = stretch - 1;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    pixel_ok: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_write && !start |-> pixel_out == ref_px)
        else begin
            errors++;
            $display("Error: pixel_out = %h, expected %h at x = %h",
                     $sampled(pixel_out), $sampled(ref_px), $sampled(wr_cnt));
        end

    count_ok: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_write && !start |-> wr_cnt < ppu_pkg::screen_w)
        else begin
            errors++;
            $display("More than 160 pixels written in one line");
        end

    done_ok: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |-> wr_cnt == ppu_pkg::screen_w && !fifo_write)
        else begin
            errors++;
            $display("Error: wr_cnt = %h, expected %h, fifo_write = %h at done",
                     $sampled(wr_cnt), ppu_pkg::screen_w, $sampled(fifo_write));
        end

    done_once: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> !done)
        else begin
            errors++;
            $display("done stayed high for more than one cycle");
        end

    quiet_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        line_done && !start |-> !fifo_write)
        else begin
            errors++;
            $display("Pixel written after done and before the next start");
        end

    stall_ok: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(fifo_write) && wr_cnt != 0 && !start |-> $past(fifo_empty, 2))
        else begin
            errors++;
            $display("Row started while the FIFO was not empty");
        end

    reset_ok: assert property (@(posedge clk)
        ((!rst_n && cyc > 0) || $rose(rst_n)) |-> !fifo_write && !done)
        else begin
            errors++;
            $display("Error: fifo_write = %h, done = %h during reset, expected 0",
                     $sampled(fifo_write), $sampled(done));
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic begin_line(input logic [7:0] l, input logic [7:0] x,
                              input logic [7:0] y, input logic [7:0] row);
        @(posedge clk);
        #1;
        lcdc  = l;
        scx   = x;
        scy   = y;
        ly    = row;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic run_line(input logic [7:0] l, input logic [7:0] x,
                            input logic [7:0] y, input logic [7:0] row);
        begin_line(l, x, y, row);
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        lines_run++;
    endtask

    initial begin
        start      = 1'b0;
        lcdc       = 8'h91;
        scx        = 8'h00;
        scy        = 8'h00;
        ly         = 8'h00;
        fifo_empty = 1'b1;
        wait (rst_n);
        run_line(8'h91, 8'd0, 8'd0, 8'd0);
        run_line(8'h91, 8'd13, 8'd7, 8'd42);
        run_line(8'h81, 8'd5, 8'd250, 8'd100);
        run_line(8'h89, 8'd255, 8'd3, 8'd143);
        run_line(8'h99, 8'd77, 8'd129, 8'd10);
        // Background off
        run_line(8'h90, 8'd21, 8'd33, 8'd5);
        // Restart in mid-line
        begin_line(8'h91, 8'd6, 8'd60, 8'd20);
        while (wr_cnt < 50) begin
            @(posedge clk);
            #1;
        end
        run_line(8'h89, 8'd130, 8'd90, 8'd77);
        repeat (5) @(posedge clk);
        $display("Lines run: %0d, errors: %0d", lines_run, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/ppu_pkg.sv
src/tile_addr_calc.sv
src/fetch_sequencer.sv
src/pixel_serializer.sv
src/bg_fetcher_top.sv
testbench/tb_clock.sv
testbench/tb_vram.sv
testbench/tb_top.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_top -Mdir obj_dir -o sim

# Pass only when the simulator prints the pass line
run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
